// ==== rtl/cp0_pkg.sv ====
package cp0_pkg;

	// basic widths
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [2:0]  reg_sel_t;
	typedef logic [4:0]  exc_code_t;

	// register numbers
	localparam reg_addr_t REG_BADVADDR = 5'd8;
	localparam reg_addr_t REG_COUNT    = 5'd9;
	localparam reg_addr_t REG_COMPARE  = 5'd11;
	localparam reg_addr_t REG_STATUS   = 5'd12;
	localparam reg_addr_t REG_CAUSE    = 5'd13;
	localparam reg_addr_t REG_EPC      = 5'd14;

	localparam reg_sel_t SEL_DEFAULT = 3'd0;	// every register here lives at select 0

	// status fields
	localparam int STATUS_IE    = 0;
	localparam int STATUS_EXL   = 1;
	localparam int STATUS_IM_LO = 8;
	localparam int STATUS_IM_HI = 15;
	localparam int STATUS_BEV   = 22;	// reads as 1, not stored

	// cause fields
	localparam int CAUSE_EXC_LO = 2;
	localparam int CAUSE_EXC_HI = 6;
	localparam int CAUSE_IP_LO  = 8;	// ip1..0 software, ip7..2 hardware
	localparam int CAUSE_IP_HI  = 15;
	localparam int CAUSE_BD     = 31;

	// interrupt lines
	localparam int HW_IRQ_N = 6;
	localparam int SW_IRQ_N = 2;

	// exception request bits, lowest index wins
	localparam int EXC_N        = 7;
	localparam int EXC_REQ_ADEL = 0;
	localparam int EXC_REQ_ADES = 1;
	localparam int EXC_REQ_SYS  = 2;
	localparam int EXC_REQ_BP   = 3;
	localparam int EXC_REQ_RI   = 4;
	localparam int EXC_REQ_OV   = 5;
	localparam int EXC_REQ_TR   = 6;

	// ExcCode values written to cause
	localparam exc_code_t CODE_INT  = 5'd0;
	localparam exc_code_t CODE_ADEL = 5'd4;
	localparam exc_code_t CODE_ADES = 5'd5;
	localparam exc_code_t CODE_SYS  = 5'd8;
	localparam exc_code_t CODE_BP   = 5'd9;
	localparam exc_code_t CODE_RI   = 5'd10;
	localparam exc_code_t CODE_OV   = 5'd12;
	localparam exc_code_t CODE_TR   = 5'd13;

	// EPC points at the branch when the victim sits in its delay slot
	localparam word_t DELAY_SLOT_OFFSET = 32'd4;

endpackage

// ==== rtl/cp0_exc_ctrl.sv ====
`timescale 1ns/1ps

module cp0_exc_ctrl #(
	parameter cp0_pkg::word_t EXC_VECTOR = 32'hbfc00380
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             wcp0,
	input  cp0_pkg::reg_addr_t               waddr,
	input  cp0_pkg::reg_sel_t                wsel,
	input  cp0_pkg::word_t                   wdata,
	input  logic                             eret,
	input  logic [cp0_pkg::EXC_N-1:0]        exc_req,
	input  logic [cp0_pkg::HW_IRQ_N-1:0]     int_i,
	input  logic                             timer_irq,
	input  logic [cp0_pkg::SW_IRQ_N-1:0]     sw_pending,
	input  cp0_pkg::word_t                   epc,
	output cp0_pkg::word_t                   status,
	output logic                             capture,
	output logic                             record,
	output logic                             write_block,
	output cp0_pkg::exc_code_t               exc_code,
	output logic [cp0_pkg::HW_IRQ_N-1:0]     hw_pending,
	output logic                             exc_en,
	output cp0_pkg::word_t                   pc_exc
);
	import cp0_pkg::*;

	typedef enum logic {
		NORMAL,
		EXC_LEVEL
	} state_t;

	state_t state_q;
	state_t state_d;
	logic ie_q;
	logic [STATUS_IM_HI-STATUS_IM_LO:0] im_q;
	logic exl;
	logic any_exc;
	logic take_eret;
	logic take_hw;
	logic take_sw;
	logic status_we;
	logic epc_fwd;
	logic [HW_IRQ_N-1:0] hw_irq;
	logic [SW_IRQ_N-1:0] sw_irq;

	assign exl = (state_q == EXC_LEVEL);

	// timer shares hardware line 5
	assign hw_pending = {int_i[HW_IRQ_N-1] | timer_irq, int_i[HW_IRQ_N-2:0]};
	assign hw_irq = hw_pending & im_q[HW_IRQ_N+SW_IRQ_N-1:SW_IRQ_N];
	assign sw_irq = sw_pending & im_q[SW_IRQ_N-1:0];

	assign any_exc = |exc_req;
	assign take_eret = eret & ~any_exc;
	assign take_hw = ~eret & ~any_exc & ie_q & ~exl & (|hw_irq);
	assign take_sw = ~eret & ~any_exc & ie_q & ~exl & ~(|hw_irq) & (|sw_irq);

	assign capture = ~exl & (any_exc | take_hw | take_sw);
	assign record = exl & any_exc;	// nested exception only leaves its code
	assign write_block = take_eret | any_exc | take_hw | take_sw;
	assign exc_en = write_block;

	assign status_we = wcp0 & ~write_block & (waddr == REG_STATUS) & (wsel == SEL_DEFAULT);
	assign epc_fwd = wcp0 & (waddr == REG_EPC) & (wsel == SEL_DEFAULT);

	// fixed priority over the request bits
	always_comb
	begin
		if (exc_req[EXC_REQ_ADEL])
			exc_code = CODE_ADEL;
		else if (exc_req[EXC_REQ_ADES])
			exc_code = CODE_ADES;
		else if (exc_req[EXC_REQ_SYS])
			exc_code = CODE_SYS;
		else if (exc_req[EXC_REQ_BP])
			exc_code = CODE_BP;
		else if (exc_req[EXC_REQ_RI])
			exc_code = CODE_RI;
		else if (exc_req[EXC_REQ_OV])
			exc_code = CODE_OV;
		else if (exc_req[EXC_REQ_TR])
			exc_code = CODE_TR;
		else
			exc_code = CODE_INT;	// interrupt when nothing synchronous
	end

	always_comb
	begin
		if (take_eret)
			pc_exc = epc_fwd ? wdata : epc;	// epc written by the older instruction
		else if (write_block)
			pc_exc = EXC_VECTOR;
		else
			pc_exc = '0;
	end

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			NORMAL:
			begin
				if (capture)
					state_d = EXC_LEVEL;
				else if (status_we && wdata[STATUS_EXL])
					state_d = EXC_LEVEL;
			end
			EXC_LEVEL:
			begin
				if (take_eret)
					state_d = NORMAL;
				else if (status_we && !wdata[STATUS_EXL])
					state_d = NORMAL;
			end
			default:
				state_d = NORMAL;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state_q <= NORMAL;
			ie_q <= 1'b0;
			im_q <= '0;
		end
		else
		begin
			state_q <= state_d;
			if (status_we)
			begin
				ie_q <= wdata[STATUS_IE];
				im_q <= wdata[STATUS_IM_HI:STATUS_IM_LO];
			end
		end
	end

	always_comb
	begin
		status = '0;
		status[STATUS_BEV] = 1'b1;	// boot vectors always
		status[STATUS_IM_HI:STATUS_IM_LO] = im_q;
		status[STATUS_EXL] = exl;
		status[STATUS_IE] = ie_q;
	end

endmodule

// ==== rtl/cp0_timer.sv ====
`timescale 1ns/1ps

module cp0_timer (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               wcp0,
	input  cp0_pkg::reg_addr_t waddr,
	input  cp0_pkg::reg_sel_t  wsel,
	input  cp0_pkg::word_t     wdata,
	input  logic               write_block,
	output cp0_pkg::word_t     count,
	output cp0_pkg::word_t     compare,
	output logic               timer_irq
);
	import cp0_pkg::*;

	logic sw_we;
	logic count_we;
	logic compare_we;
	logic hit;

	assign sw_we = wcp0 & ~write_block & (wsel == SEL_DEFAULT);
	assign count_we = sw_we & (waddr == REG_COUNT);
	assign compare_we = sw_we & (waddr == REG_COMPARE);
	assign hit = (count == compare) && (count != '0);	// zero never fires

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			count <= '0;
			compare <= '0;
			timer_irq <= 1'b0;
		end
		else
		begin
			if (count_we)
				count <= wdata;
			else
				count <= count + 32'd1;

			if (compare_we)
			begin
				compare <= wdata;
				timer_irq <= 1'b0;	// acknowledge
			end
			else if (hit)
				timer_irq <= 1'b1;	// sticky
		end
	end

endmodule

// ==== rtl/cp0_reg_file.sv ====
`timescale 1ns/1ps

module cp0_reg_file (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             wcp0,
	input  cp0_pkg::reg_addr_t               waddr,
	input  cp0_pkg::reg_sel_t                wsel,
	input  cp0_pkg::word_t                   wdata,
	input  cp0_pkg::reg_addr_t               raddr,
	input  cp0_pkg::reg_sel_t                rsel,
	input  logic                             write_block,
	input  logic                             capture,
	input  logic                             record,
	input  cp0_pkg::exc_code_t               exc_code,
	input  logic [cp0_pkg::HW_IRQ_N-1:0]     hw_pending,
	input  cp0_pkg::word_t                   victim_pc,
	input  logic                             in_delay_slot,
	input  cp0_pkg::word_t                   badvaddr,
	input  cp0_pkg::word_t                   status,
	input  cp0_pkg::word_t                   count,
	input  cp0_pkg::word_t                   compare,
	output cp0_pkg::word_t                   rdata,
	output cp0_pkg::word_t                   epc,
	output logic [cp0_pkg::SW_IRQ_N-1:0]     sw_pending
);
	import cp0_pkg::*;

	logic bd_q;
	exc_code_t code_q;
	logic [HW_IRQ_N-1:0] hw_ip_q;
	logic [SW_IRQ_N-1:0] sw_ip_q;
	word_t badvaddr_q;
	logic sw_we;
	logic bypass;
	word_t cause_rd;
	word_t cause_byp;
	word_t status_byp;

	assign sw_we = wcp0 & ~write_block & (wsel == SEL_DEFAULT);
	assign bypass = wcp0 & ~write_block & (waddr == raddr) & (wsel == rsel);
	assign sw_pending = sw_ip_q;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			bd_q <= 1'b0;
			code_q <= CODE_INT;
			hw_ip_q <= '0;
			sw_ip_q <= '0;
			epc <= '0;
			badvaddr_q <= '0;
		end
		else if (capture)
		begin
			bd_q <= in_delay_slot;
			code_q <= exc_code;
			hw_ip_q <= hw_pending;
			if (in_delay_slot)
				epc <= victim_pc - DELAY_SLOT_OFFSET;	// restart at the branch
			else
				epc <= victim_pc;
			if (exc_code == CODE_ADEL && victim_pc[1:0] != 2'b00)
				badvaddr_q <= victim_pc;	// fetch fault comes first
			else if (exc_code == CODE_ADEL || exc_code == CODE_ADES)
				badvaddr_q <= badvaddr;
		end
		else if (record)
		begin
			code_q <= exc_code;
			hw_ip_q <= hw_pending;
		end
		else if (sw_we)
		begin
			case (waddr)
				REG_CAUSE:
					sw_ip_q <= wdata[CAUSE_IP_LO+SW_IRQ_N-1:CAUSE_IP_LO];	// only ip1..0 writable
				REG_EPC:
					epc <= wdata;
				REG_BADVADDR:
					badvaddr_q <= wdata;
				default:
				begin
				end
			endcase
		end
	end

	// recorded lines plus the ones asserted now
	always_comb
	begin
		cause_rd = '0;
		cause_rd[CAUSE_BD] = bd_q;
		cause_rd[CAUSE_IP_HI:CAUSE_IP_LO] = {hw_ip_q | hw_pending, sw_ip_q};
		cause_rd[CAUSE_EXC_HI:CAUSE_EXC_LO] = code_q;
	end

	always_comb
	begin
		cause_byp = '0;
		cause_byp[CAUSE_BD] = wdata[CAUSE_BD];
		cause_byp[CAUSE_IP_HI:CAUSE_IP_LO] = wdata[CAUSE_IP_HI:CAUSE_IP_LO];
		cause_byp[CAUSE_EXC_HI:CAUSE_EXC_LO] = wdata[CAUSE_EXC_HI:CAUSE_EXC_LO];
		status_byp = '0;
		status_byp[STATUS_BEV] = 1'b1;
		status_byp[STATUS_IM_HI:STATUS_IM_LO] = wdata[STATUS_IM_HI:STATUS_IM_LO];
		status_byp[STATUS_EXL] = wdata[STATUS_EXL];
		status_byp[STATUS_IE] = wdata[STATUS_IE];
	end

	always_comb
	begin
		rdata = '0;
		if (rsel == SEL_DEFAULT)
		begin
			case (raddr)
				REG_BADVADDR:
					rdata = bypass ? wdata : badvaddr_q;
				REG_COUNT:
					rdata = bypass ? wdata : count;
				REG_COMPARE:
					rdata = bypass ? wdata : compare;
				REG_STATUS:
					rdata = bypass ? status_byp : status;
				REG_CAUSE:
					rdata = bypass ? cause_byp : cause_rd;
				REG_EPC:
					rdata = bypass ? wdata : epc;
				default:
					rdata = '0;	// unimplemented
			endcase
		end
	end

endmodule

// ==== rtl/cp0_top.sv ====
`timescale 1ns/1ps

module cp0_top #(
	parameter cp0_pkg::word_t EXC_VECTOR = 32'hbfc00380
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             wcp0,
	input  cp0_pkg::reg_addr_t               waddr,
	input  cp0_pkg::reg_sel_t                wsel,
	input  cp0_pkg::word_t                   wdata,
	input  cp0_pkg::reg_addr_t               raddr,
	input  cp0_pkg::reg_sel_t                rsel,
	input  logic                             eret,
	input  logic [cp0_pkg::EXC_N-1:0]        exc_req,
	input  logic [cp0_pkg::HW_IRQ_N-1:0]     int_i,
	input  cp0_pkg::word_t                   victim_pc,
	input  logic                             in_delay_slot,
	input  cp0_pkg::word_t                   badvaddr,
	output cp0_pkg::word_t                   rdata,
	output logic                             exc_en,
	output cp0_pkg::word_t                   pc_exc
);
	import cp0_pkg::*;

	word_t status;
	word_t epc;
	word_t count;
	word_t compare;
	logic timer_irq;
	logic capture;
	logic record;
	logic write_block;
	exc_code_t exc_code;
	logic [HW_IRQ_N-1:0] hw_pending;
	logic [SW_IRQ_N-1:0] sw_pending;

	cp0_exc_ctrl #(
		.EXC_VECTOR(EXC_VECTOR)
	) exc_ctrl_i (
		.clk(clk),
		.rst_n(rst_n),
		.wcp0(wcp0),
		.waddr(waddr),
		.wsel(wsel),
		.wdata(wdata),
		.eret(eret),
		.exc_req(exc_req),
		.int_i(int_i),
		.timer_irq(timer_irq),
		.sw_pending(sw_pending),
		.epc(epc),
		.status(status),
		.capture(capture),
		.record(record),
		.write_block(write_block),
		.exc_code(exc_code),
		.hw_pending(hw_pending),
		.exc_en(exc_en),
		.pc_exc(pc_exc)
	);

	cp0_timer timer_i (
		.clk(clk),
		.rst_n(rst_n),
		.wcp0(wcp0),
		.waddr(waddr),
		.wsel(wsel),
		.wdata(wdata),
		.write_block(write_block),
		.count(count),
		.compare(compare),
		.timer_irq(timer_irq)
	);

	cp0_reg_file reg_file_i (
		.clk(clk),
		.rst_n(rst_n),
		.wcp0(wcp0),
		.waddr(waddr),
		.wsel(wsel),
		.wdata(wdata),
		.raddr(raddr),
		.rsel(rsel),
		.write_block(write_block),
		.capture(capture),
		.record(record),
		.exc_code(exc_code),
		.hw_pending(hw_pending),
		.victim_pc(victim_pc),
		.in_delay_slot(in_delay_slot),
		.badvaddr(badvaddr),
		.status(status),
		.count(count),
		.compare(compare),
		.rdata(rdata),
		.epc(epc),
		.sw_pending(sw_pending)
	);

endmodule

// ==== sim/cp0_tb.sv ====
`timescale 1ns/1ps

module cp0_tb;
	import cp0_pkg::*;

	localparam int EDGE_TIMEOUT = 100;	// ns of polling per clock edge
	localparam int SAMPLE_DELAY = 15;	// after the falling edge, before the rising one
	localparam int FIELDS = 16;
	localparam int RESET_CYCLES = 8;

	logic clk = 1'b0;
	logic rst_n;
	logic wcp0;
	reg_addr_t waddr;
	reg_sel_t wsel;
	word_t wdata;
	reg_addr_t raddr;
	reg_sel_t rsel;
	logic eret;
	logic [EXC_N-1:0] exc_req;
	logic [HW_IRQ_N-1:0] int_i;
	word_t victim_pc;
	logic in_delay_slot;
	word_t badvaddr;
	word_t rdata;
	logic exc_en;
	word_t pc_exc;

	int fd;
	int n;
	int cnt;
	int i;
	int test_num;
	int cur_test;
	int tests;
	int checks;
	int errors;
	int test_cycles;
	int test_errors;
	bit aborted;
	string line;
	word_t fld [0:14];	// one vector line after the test number

	always #20 clk = ~clk;

	cp0_top #(
		.EXC_VECTOR(32'hbfc00380)
	) dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.wcp0(wcp0),
		.waddr(waddr),
		.wsel(wsel),
		.wdata(wdata),
		.raddr(raddr),
		.rsel(rsel),
		.eret(eret),
		.exc_req(exc_req),
		.int_i(int_i),
		.victim_pc(victim_pc),
		.in_delay_slot(in_delay_slot),
		.badvaddr(badvaddr),
		.rdata(rdata),
		.exc_en(exc_en),
		.pc_exc(pc_exc)
	);

	// polls for the next falling edge
	task automatic wait_fall;
		int steps;
		steps = 0;
		while (clk !== 1'b1 && steps < EDGE_TIMEOUT)
		begin
			#1;
			steps++;
		end
		while (clk !== 1'b0 && steps < EDGE_TIMEOUT)
		begin
			#1;
			steps++;
		end
		if (steps >= EDGE_TIMEOUT)
		begin
			$display("clock edge did not arrive within %0d ns", EDGE_TIMEOUT);
			aborted = 1'b1;
		end
	endtask

	task automatic check_val(input string name, input word_t got, input word_t expected);
		checks++;
		if (got !== expected)
		begin
			errors++;
			test_errors++;
			$display("FAILED at %0t: %s got %08h expected %08h", $time, name, got, expected);
		end
	endtask

	task automatic apply_vector;
		wcp0 = fld[0][0];
		waddr = fld[1][4:0];
		wsel = fld[2][2:0];
		wdata = fld[3];
		raddr = fld[4][4:0];
		rsel = fld[5][2:0];
		eret = fld[6][0];
		exc_req = fld[7][EXC_N-1:0];
		int_i = fld[8][HW_IRQ_N-1:0];
		victim_pc = fld[9];
		in_delay_slot = fld[10][0];
		badvaddr = fld[11];
	endtask

	task automatic finish_test;
		$display("test %0d finished: %0d cycles, %0d mismatches", cur_test, test_cycles,
			test_errors);
		test_cycles = 0;
		test_errors = 0;
	endtask

	// one clock cycle of stimulus and checks
	task automatic run_cycle;
		if (test_num != cur_test)
		begin
			if (cur_test != 0)
				finish_test();
			cur_test = test_num;
			tests++;
		end
		apply_vector();
		#(SAMPLE_DELAY);
		test_cycles++;
		check_val("exc_en", {31'b0, exc_en}, fld[12]);
		check_val("pc_exc", pc_exc, fld[13]);
		check_val("rdata", rdata, fld[14]);
		wait_fall();
	endtask

	initial
	begin
		rst_n = 1'b0;
		wcp0 = 1'b0;
		waddr = '0;
		wsel = '0;
		wdata = '0;
		raddr = '0;
		rsel = '0;
		eret = 1'b0;
		exc_req = '0;
		int_i = '0;
		victim_pc = '0;
		in_delay_slot = 1'b0;
		badvaddr = '0;
		aborted = 1'b0;
		tests = 0;
		checks = 0;
		errors = 0;
		cur_test = 0;
		test_cycles = 0;
		test_errors = 0;
		fd = 0;

		for (i = 0; i < RESET_CYCLES && !aborted; i++)
			wait_fall();
		rst_n = 1'b1;	// first vector goes out on this same falling edge

		if (!aborted)
		begin
			fd = $fopen("sim/cp0_vectors.txt", "r");
			if (fd == 0)
			begin
				$display("vector file sim/cp0_vectors.txt could not be opened");
				aborted = 1'b1;
			end
		end

		while (!aborted && !$feof(fd))
		begin
			line = "";
			n = $fgets(line, fd);
			if (n > 1 && line.getc(0) != 8'h23)	// skip comment lines
			begin
				cnt = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					test_num, fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
					fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14]);
				if (cnt != FIELDS)
				begin
					$display("malformed vector line, %0d of %0d fields read: %s", cnt,
						FIELDS, line);
					aborted = 1'b1;
				end
				else
					run_cycle();
			end
		end

		if (fd != 0)
			$fclose(fd);
		if (cur_test != 0)
			finish_test();
		if (tests == 0 && !aborted)
		begin
			$display("no vectors were found in sim/cp0_vectors.txt");
			aborted = 1'b1;
		end

		$display("%0d tests, %0d checks, %0d mismatches", tests, checks, errors);
		if (errors == 0 && !aborted)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== cp0_top.f ====
rtl/cp0_pkg.sv
rtl/cp0_exc_ctrl.sv
rtl/cp0_timer.sv
rtl/cp0_reg_file.sv
rtl/cp0_top.sv
sim/cp0_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the cp0 testbench with Verilator and runs it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module cp0_tb -f cp0_top.f -o cp0_sim

sim_out=$(./obj_dir/cp0_sim)
echo "$sim_out"

if echo "$sim_out" | grep -q "^TEST OK$"; then
	exit 0
else
	exit 1
fi

// ==== sim/cp0_vectors.txt ====
# test wcp0 waddr wsel wdata raddr rsel eret exc_req int_i victim_pc delay_slot badvaddr
# then expected exc_en pc_exc rdata; test number decimal, all other fields hex
1 0 00 0 00000000 0c 0 0 00 00 00000000 0 00000000 0 00000000 00400000
1 0 00 0 00000000 09 0 0 00 00 00000000 0 00000000 0 00000000 00000001
1 0 00 0 00000000 09 0 0 00 00 00000000 0 00000000 0 00000000 00000002
1 0 00 0 00000000 09 0 0 00 00 00000000 0 00000000 0 00000000 00000003
1 0 00 0 00000000 0d 0 0 00 00 00000000 0 00000000 0 00000000 00000000
1 0 00 0 00000000 0e 0 0 00 00 00000000 0 00000000 0 00000000 00000000
2 1 0e 0 80001234 00 0 0 00 00 00000000 0 00000000 0 00000000 00000000
2 0 00 0 00000000 0e 0 0 00 00 00000000 0 00000000 0 00000000 80001234
2 1 0b 0 00001000 0b 0 0 00 00 00000000 0 00000000 0 00000000 00001000
2 0 00 0 00000000 0b 0 0 00 00 00000000 0 00000000 0 00000000 00001000
2 1 0c 0 1234ff00 0c 0 0 00 00 00000000 0 00000000 0 00000000 0040ff00
2 0 00 0 00000000 0c 0 0 00 00 00000000 0 00000000 0 00000000 0040ff00
2 1 08 0 00000abc 08 0 0 00 00 00000000 0 00000000 0 00000000 00000abc
2 0 00 0 00000000 08 0 0 00 00 00000000 0 00000000 0 00000000 00000abc
3 0 00 0 00000000 00 0 0 04 00 80000100 0 00000000 1 bfc00380 00000000
3 0 00 0 00000000 0e 0 0 00 00 00000000 0 00000000 0 00000000 80000100
3 0 00 0 00000000 0d 0 0 00 00 00000000 0 00000000 0 00000000 00000020
3 0 00 0 00000000 0c 0 0 00 00 00000000 0 00000000 0 00000000 0040ff02
3 1 0c 0 0000ff00 0c 0 0 00 00 00000000 0 00000000 0 00000000 0040ff00
3 0 00 0 00000000 00 0 0 04 00 80000204 1 00000000 1 bfc00380 00000000
3 0 00 0 00000000 0e 0 0 00 00 00000000 0 00000000 0 00000000 80000200
3 0 00 0 00000000 0d 0 0 00 00 00000000 0 00000000 0 00000000 80000020
3 1 0c 0 0000ff00 00 0 0 00 00 00000000 0 00000000 0 00000000 00000000
3 0 00 0 00000000 00 0 0 01 00 80000302 0 12345678 1 bfc00380 00000000
3 0 00 0 00000000 08 0 0 00 00 00000000 0 00000000 0 00000000 80000302
3 0 00 0 00000000 0d 0 0 00 00 00000000 0 00000000 0 00000000 00000010
4 0 00 0 00000000 00 0 1 00 00 00000000 0 00000000 1 80000302 00000000
4 0 00 0 00000000 0c 0 0 00 00 00000000 0 00000000 0 00000000 0040ff00
4 1 0e 0 80000500 0e 0 1 00 00 00000000 0 00000000 1 80000500 80000302
4 0 00 0 00000000 0e 0 0 00 00 00000000 0 00000000 0 00000000 80000302
4 0 00 0 00000000 00 0 0 04 00 80000600 0 00000000 1 bfc00380 00000000
4 0 00 0 00000000 00 0 0 60 00 80000700 1 00000000 1 bfc00380 00000000
4 0 00 0 00000000 0d 0 0 00 00 00000000 0 00000000 0 00000000 00000030
4 0 00 0 00000000 0e 0 0 00 00 00000000 0 00000000 0 00000000 80000600
4 0 00 0 00000000 00 0 1 00 00 00000000 0 00000000 1 80000600 00000000
4 0 00 0 00000000 0c 0 0 00 00 00000000 0 00000000 0 00000000 0040ff00
5 0 00 0 00000000 0d 0 0 00 01 00000000 0 00000000 0 00000000 00000430
5 1 0c 0 0000ff01 0c 0 0 00 00 00000000 0 00000000 0 00000000 0040ff01
5 0 00 0 00000000 00 0 0 00 04 80000800 0 00000000 1 bfc00380 00000000
5 0 00 0 00000000 0d 0 0 00 00 00000000 0 00000000 0 00000000 00001000
5 0 00 0 00000000 0e 0 0 00 00 00000000 0 00000000 0 00000000 80000800
5 0 00 0 00000000 0d 0 0 00 01 00000000 0 00000000 0 00000000 00001400
5 0 00 0 00000000 00 0 1 00 00 00000000 0 00000000 1 80000800 00000000
5 1 0c 0 00000001 0c 0 0 00 00 00000000 0 00000000 0 00000000 00400001
5 0 00 0 00000000 0d 0 0 00 3f 00000000 0 00000000 0 00000000 0000fc00
5 1 0c 0 0000ff01 00 0 0 00 00 00000000 0 00000000 0 00000000 00000000
5 1 0d 0 00000100 0d 0 0 00 00 00000000 0 00000000 0 00000000 00000100
5 0 00 0 00000000 00 0 0 00 00 80000900 0 00000000 1 bfc00380 00000000
5 0 00 0 00000000 0d 0 0 00 00 00000000 0 00000000 0 00000000 00000100
5 1 0d 0 00000000 00 0 0 00 00 00000000 0 00000000 0 00000000 00000000
5 0 00 0 00000000 00 0 1 00 00 00000000 0 00000000 1 80000900 00000000
5 1 0c 0 00000000 0c 0 0 00 00 00000000 0 00000000 0 00000000 00400000
6 1 0b 0 00000014 00 0 0 00 00 00000000 0 00000000 0 00000000 00000000
6 1 09 0 00000000 09 0 0 00 00 00000000 0 00000000 0 00000000 00000000
6 0 00 0 00000000 09 0 0 00 00 00000000 0 00000000 0 00000000 00000000
6 0 00 0 00000000 09 0 0 00 00 00000000 0 00000000 0 00000000 00000001
6 0 00 0 00000000 0d 0 0 00 00 00000000 0 00000000 0 00000000 00000000
6 0 00 0 00000000 0d 0 0 00 00 00000000 0 00000000 0 00000000 00000000
6 0 00 0 00000000 0d 0 0 00 00 00000000 0 00000000 0 00000000 00000000
6 0 00 0 00000000 0d 0 0 00 00 00000000 0 00000000 0 00000000 00000000
6 0 00 0 00000000 0d 0 0 00 00 00000000 0 00000000 0 00000000 00000000
6 0 00 0 00000000 0d 0 0 00 00 00000000 0 00000000 0 00000000 00000000
6 0 00 0 00000000 0d 0 0 00 00 00000000 0 00000000 0 00000000 00000000
6 0 00 0 00000000 0d 0 0 00 00 00000000 0 00000000 0 00000000 00000000
6 0 00 0 00000000 0d 0 0 00 00 00000000 0 00000000 0 00000000 00000000
6 0 00 0 00000000 0d 0 0 00 00 00000000 0 00000000 0 00000000 00000000
6 0 00 0 00000000 0d 0 0 00 00 00000000 0 00000000 0 00000000 00000000
6 0 00 0 00000000 0d 0 0 00 00 00000000 0 00000000 0 00000000 00000000
6 0 00 0 00000000 0d 0 0 00 00 00000000 0 00000000 0 00000000 00000000
6 0 00 0 00000000 0d 0 0 00 00 00000000 0 00000000 0 00000000 00000000
6 0 00 0 00000000 0d 0 0 00 00 00000000 0 00000000 0 00000000 00000000
6 0 00 0 00000000 0d 0 0 00 00 00000000 0 00000000 0 00000000 00000000
6 0 00 0 00000000 0d 0 0 00 00 00000000 0 00000000 0 00000000 00000000
6 0 00 0 00000000 0d 0 0 00 00 00000000 0 00000000 0 00000000 00000000
6 0 00 0 00000000 09 0 0 00 00 00000000 0 00000000 0 00000000 00000014
6 0 00 0 00000000 0d 0 0 00 00 00000000 0 00000000 0 00000000 00008000
6 0 00 0 00000000 0d 0 0 00 00 00000000 0 00000000 0 00000000 00008000
6 1 0b 0 00000100 0d 0 0 00 00 00000000 0 00000000 0 00000000 00008000
6 0 00 0 00000000 0d 0 0 00 00 00000000 0 00000000 0 00000000 00000000
